/* filelist.f */
verilog/divCfgPkg.sv
verilog/divTypesPkg.sv
verilog/divPreproc.sv
verilog/divIter.sv
verilog/divEarlyTerm.sv
verilog/divPostproc.sv
verilog/divCtrl.sv
verilog/divUnit.sv
tests/divUnitTb.sv

/* Bender.yml */
package:
  name: divUnit

sources:
  - target: any(rtl, test)
    files:
      - verilog/divCfgPkg.sv
      - verilog/divTypesPkg.sv
      - verilog/divPreproc.sv
      - verilog/divIter.sv
      - verilog/divEarlyTerm.sv
      - verilog/divPostproc.sv
      - verilog/divCtrl.sv
      - verilog/divUnit.sv
  - target: test
    files:
      - tests/divUnitTb.sv

/* tests/divUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module divUnitTb;

  import divCfgPkg::*;
  import divTypesPkg::*;

  localparam int MAXROWS  = 48;
  localparam int NRAND    = 20;
  localparam int TIMEOUT  = 200;  // Cycles per wait
  localparam int HOLDWAIT = 50;   // Cycles with no result credit

  logic clk;
  logic rst;
  logic reqValid;
  xlenT reqA;
  xlenT reqB;
  logic reqSigned;
  logic reqRem;
  logic reqCredit;
  logic rspValid;
  xlenT rspData;
  logic rspExact;
  logic rspCredit;

  // Stimulus and expected values, one entry per test
  string nameTab[MAXROWS];
  xlenT  aTab[MAXROWS];
  xlenT  bTab[MAXROWS];
  logic  signedTab[MAXROWS];
  logic  remTab[MAXROWS];
  xlenT  expTab[MAXROWS];
  logic  exactTab[MAXROWS];
  logic  holdTab[MAXROWS];  // Withhold the result credit
  int    nRows = 0;

  int   errors = 0;
  int   protoErrors = 0;  // Found by the handshake monitor
  int   testsDone = 0;
  int   heldCredits = 0;  // Request credits not yet spent
  int   creditPulses = 0;
  int   rspPulses = 0;
  int   outstanding = 0;  // Requests without a result yet
  logic timedOut = 1'b0;  // A wait ran out of cycles
  xlenT lcgState = 32'd62;

  divUnit UUT (
    .clk, .rst, .reqValid, .reqA, .reqB, .reqSigned, .reqRem,
    .reqCredit, .rspValid, .rspData, .rspExact, .rspCredit
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic xlenT lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  // RISC-V rules, truncating division
  function automatic xlenT refQuot(input xlenT a, input xlenT b, input logic s);
    if (b == '0) return '1;
    if (s && a == 32'h80000000 && b == '1) return a;  // Overflow keeps the dividend
    if (s) return xlenT'($signed(a) / $signed(b));
    return a / b;
  endfunction

  function automatic xlenT refRem(input xlenT a, input xlenT b, input logic s);
    if (b == '0) return a;
    if (s && a == 32'h80000000 && b == '1) return '0;
    if (s) return xlenT'($signed(a) % $signed(b));  // Sign of the dividend
    return a % b;
  endfunction

  task automatic addRow(input string name, input xlenT a, input xlenT b, input logic s,
                        input logic rm, input xlenT expd, input logic ex, input logic hold);
    nameTab[nRows]   = name;
    aTab[nRows]      = a;
    bTab[nRows]      = b;
    signedTab[nRows] = s;
    remTab[nRows]    = rm;
    expTab[nRows]    = expd;
    exactTab[nRows]  = ex;
    holdTab[nRows]   = hold;
    nRows++;
  endtask

  task automatic fillRandom();
    xlenT r;
    xlenT a;
    xlenT b;
    logic s;
    logic rm;
    for (int k = 0; k < NRAND; k++) begin
      r  = lcgNext();
      a  = lcgNext();
      b  = lcgNext() >> r[31:27];  // Spread of divisor sizes
      s  = r[26];
      rm = r[25];
      if (r[24]) a = b * xlenT'(r[7:0]);  // Exact multiple, ends early
      addRow($sformatf("rand_%0d", k), a, b, s, rm,
             rm ? refRem(a, b, s) : refQuot(a, b, s), refRem(a, b, s) == '0, 1'b0);
    end
  endtask

  //////////////////////////////
  // Checks and run control
  //////////////////////////////

  task automatic checkResult(input string name, input xlenT expd, input xlenT act);
    if (act !== expd) begin
      $display("CHECK FAILED %0s result expected %h actual %h", name, expd, act);
      errors++;
    end
  endtask

  task automatic checkExact(input string name, input logic expd, input logic act);
    if (act !== expd) begin
      $display("CHECK FAILED %0s exact expected %b actual %b", name, expd, act);
      errors++;
    end
  endtask

  task automatic endRun();
    $display("%0d tests run, %0d errors", testsDone, errors + protoErrors);
    if (!timedOut && errors + protoErrors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // Returns on a rising edge with a credit in hand
  task automatic waitCredit();
    int i;
    i = 0;
    @(posedge clk);
    while (heldCredits == 0 && i < TIMEOUT) begin
      @(posedge clk);
      i++;
    end
    if (heldCredits == 0) begin
      $display("Timed out waiting for a request credit");
      timedOut = 1'b1;
    end
  endtask

  task automatic giveRspCredit();
    @(posedge clk);
    #1 rspCredit = 1'b1;
    @(posedge clk);
    #1 rspCredit = 1'b0;
  endtask

  task automatic waitResponse(output xlenT data, output logic exact);
    int i;
    i = 0;
    @(negedge clk);
    while (!rspValid && i < TIMEOUT) begin
      @(negedge clk);
      i++;
    end
    if (!rspValid) begin
      $display("Timed out waiting for a result");
      timedOut = 1'b1;
    end else begin
      data  = rspData;
      exact = rspExact;
    end
  endtask

  task automatic runRow(input int t);
    int   errBefore;
    xlenT data;
    logic exact;
    errBefore = errors;
    waitCredit();
    if (timedOut) return;
    #1;
    reqValid    = 1'b1;  // Spends the credit
    reqA        = aTab[t];
    reqB        = bTab[t];
    reqSigned   = signedTab[t];
    reqRem      = remTab[t];
    heldCredits--;
    outstanding++;
    @(posedge clk);
    #1 reqValid = 1'b0;
    if (holdTab[t]) begin
      // No result credit yet, so nothing may come out
      for (int i = 0; i < HOLDWAIT; i++) begin
        @(negedge clk);
        if (rspValid) begin
          $display("%0s: result sent without a result credit", nameTab[t]);
          errors++;
        end
      end
    end
    giveRspCredit();
    waitResponse(data, exact);
    if (timedOut) return;
    @(negedge clk);
    if (rspValid) begin
      $display("%0s: more than one result for one credit", nameTab[t]);
      errors++;
    end
    checkResult(nameTab[t], expTab[t], data);
    checkExact(nameTab[t], exactTab[t], exact);
    testsDone++;
    if (errors == errBefore) $display("%-16s ok        %h exact %b", nameTab[t], data, exact);
    else $display("%-16s mismatch", nameTab[t]);
  endtask

  // Credit and result bookkeeping, sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (reqCredit) begin
        heldCredits++;
        creditPulses++;
        if (heldCredits > REQCREDITS) begin
          $display("More request credits held than were granted");
          protoErrors++;
        end
      end
      if (rspValid) begin
        rspPulses++;
        if (outstanding == 0) begin
          $display("Result sent with no request outstanding");
          protoErrors++;
        end else begin
          outstanding--;
        end
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst       = 1'b1;
    reqValid  = 1'b0;
    reqA      = '0;
    reqB      = '0;
    reqSigned = 1'b0;
    reqRem    = 1'b0;
    rspCredit = 1'b0;

    addRow("divu_basic", 32'd100, 32'd7, 1'b0, 1'b0, 32'd14, 1'b0, 1'b0);
    addRow("remu_basic", 32'd100, 32'd7, 1'b0, 1'b1, 32'd2, 1'b0, 1'b0);
    addRow("div_neg_a", 32'hFFFFFF9C, 32'd7, 1'b1, 1'b0, 32'hFFFFFFF2, 1'b0, 1'b0);
    addRow("rem_neg_a", 32'hFFFFFF9C, 32'd7, 1'b1, 1'b1, 32'hFFFFFFFE, 1'b0, 1'b0);
    addRow("div_neg_b", 32'd100, 32'hFFFFFFF9, 1'b1, 1'b0, 32'hFFFFFFF2, 1'b0, 1'b0);
    addRow("rem_neg_b", 32'd100, 32'hFFFFFFF9, 1'b1, 1'b1, 32'd2, 1'b0, 1'b0);
    addRow("div_neg_both", 32'hFFFFFF9C, 32'hFFFFFFF9, 1'b1, 1'b0, 32'd14, 1'b0, 1'b0);
    addRow("rem_neg_both", 32'hFFFFFF9C, 32'hFFFFFFF9, 1'b1, 1'b1, 32'hFFFFFFFE, 1'b0, 1'b0);
    addRow("divu_by_zero", 32'h3039, 32'd0, 1'b0, 1'b0, 32'hFFFFFFFF, 1'b0, 1'b0);
    addRow("remu_by_zero", 32'h3039, 32'd0, 1'b0, 1'b1, 32'h3039, 1'b0, 1'b0);
    addRow("div_by_zero", 32'hFFFFFFFB, 32'd0, 1'b1, 1'b0, 32'hFFFFFFFF, 1'b0, 1'b0);
    addRow("rem_by_zero", 32'hFFFFFFFB, 32'd0, 1'b1, 1'b1, 32'hFFFFFFFB, 1'b0, 1'b0);
    addRow("div_small", 32'd3, 32'd10, 1'b1, 1'b0, 32'd0, 1'b0, 1'b0);
    addRow("rem_small_neg", 32'hFFFFFFFD, 32'd10, 1'b1, 1'b1, 32'hFFFFFFFD, 1'b0, 1'b0);
    addRow("div_overflow", 32'h80000000, 32'hFFFFFFFF, 1'b1, 1'b0, 32'h80000000, 1'b1, 1'b0);
    addRow("rem_overflow", 32'h80000000, 32'hFFFFFFFF, 1'b1, 1'b1, 32'd0, 1'b1, 1'b0);
    addRow("divu_pow2", 32'h40000000, 32'h10, 1'b0, 1'b0, 32'h04000000, 1'b1, 1'b0);
    addRow("remu_pow2", 32'h40000000, 32'h10, 1'b0, 1'b1, 32'd0, 1'b1, 1'b0);
    addRow("divu_multiple", 32'hFFFFFFFF, 32'h0000FFFF, 1'b0, 1'b0, 32'h00010001, 1'b1, 1'b0);
    addRow("div_mult_neg", 32'hFFFFFF70, 32'd12, 1'b1, 1'b0, 32'hFFFFFFF4, 1'b1, 1'b0);
    addRow("div_zero_num", 32'd0, 32'd5, 1'b1, 1'b0, 32'd0, 1'b1, 1'b0);
    addRow("divu_held", 32'd1000, 32'd10, 1'b0, 1'b0, 32'd100, 1'b1, 1'b1);
    fillRandom();

    repeat (5) @(posedge clk);
    #1 rst = 1'b0;

    // Initial grant only, and no stray result
    repeat (10) @(posedge clk);
    if (creditPulses != REQCREDITS) begin
      $display("CHECK FAILED reset_credits expected %0d actual %0d", REQCREDITS, creditPulses);
      errors++;
    end

    for (int t = 0; t < nRows && !timedOut; t++) runRow(t);

    if (!timedOut) waitCredit();  // Credit returned after the last result
    if (!timedOut) begin
      repeat (4) @(posedge clk);
      if (creditPulses != REQCREDITS + nRows) begin
        $display("CHECK FAILED credit_count expected %0d actual %0d",
                 REQCREDITS + nRows, creditPulses);
        errors++;
      end
      if (rspPulses != nRows) begin
        $display("CHECK FAILED result_count expected %0d actual %0d", nRows, rspPulses);
        errors++;
      end
    end
    endRun();
  end

endmodule

`default_nettype wire

/* verilog/divUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module divUnit (
  input  logic              clk,
  input  logic              rst,
  input  logic              reqValid,
  input  divTypesPkg::xlenT reqA,
  input  divTypesPkg::xlenT reqB,
  input  logic              reqSigned,
  input  logic              reqRem,
  output logic              reqCredit,
  output logic              rspValid,
  output divTypesPkg::xlenT rspData,
  output logic              rspExact,
  input  logic              rspCredit
);

  import divTypesPkg::*;

  // Sequencer strobes
  logic     start;
  logic     step;
  logic     capture;
  shiftT    remainingSteps;

  // Preprocessed operands and flags
  residualT aNorm;
  residualT dNorm;
  shiftT    iterCount;
  shiftT    intNormShift;
  logic     bZero;
  logic     aLtB;
  logic     aSign;
  logic     negQuot;
  xlenT     aOrig;

  // Recurrence state
  residualT WS;
  residualT WC;
  residualT D;
  quotT     U;
  quotT     UM;
  logic     wZero;

  divCtrl ctrl (
    .clk, .rst, .reqValid, .iterCount, .wZero, .bZero, .aLtB, .rspCredit,
    .start, .step, .capture, .remainingSteps, .rspValid, .reqCredit
  );

  divPreproc preproc (
    .clk, .rst, .start, .reqA, .reqB, .reqSigned,
    .aNorm, .dNorm, .iterCount, .intNormShift, .bZero, .aLtB,
    .aSign, .bSign(), .negQuot, .aOrig  // Divisor sign only feeds negQuot
  );

  divIter iter (
    .clk, .rst, .start, .step, .aNorm, .dNorm,
    .WS, .WC, .D, .U, .UM
  );

  divEarlyTerm earlyTerm (.WS, .WC, .wZero);

  divPostproc postproc (
    .clk, .rst, .start, .capture, .WS, .WC, .D, .U, .UM, .wZero,
    .remainingSteps, .intNormShift, .bZero, .aLtB, .aSign, .negQuot,
    .reqRem, .aOrig, .rspData, .rspExact
  );

endmodule

`default_nettype wire

/* verilog/divCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module divCtrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               reqValid,
  input  divTypesPkg::shiftT iterCount,
  input  logic               wZero,
  input  logic               bZero,
  input  logic               aLtB,
  input  logic               rspCredit,       // One result credit
  output logic               start,
  output logic               step,
  output logic               capture,
  output divTypesPkg::shiftT remainingSteps,
  output logic               rspValid,
  output logic               reqCredit        // One request credit
);

  import divCfgPkg::*;
  import divTypesPkg::*;

  divStateT           state;
  divStateT           nextState;
  shiftT              cnt;         // Digits still owed
  logic [DIVBLEN-1:0] rspCredits;  // Result credits on hand
  logic [DIVBLEN-1:0] initLeft;    // Request credits not yet issued
  logic               special;

  assign special = bZero | aLtB;

  always_comb begin
    nextState = state;
    case (state)
      IDLE: if (reqValid) nextState = PRE;
      PRE:  nextState = special ? POST : ITER;  // Special cases skip ITER
      ITER: if (wZero || cnt == 1) nextState = POST;
      POST: nextState = HOLD;
      HOLD: if (rspCredits != '0) nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) state <= IDLE;
    else state <= nextState;
  end

  // Step count, frozen on early exit
  always_ff @(posedge clk) begin
    if (rst) cnt <= '0;
    else if (state == PRE) cnt <= iterCount;
    else if (step) cnt <= cnt - 1'b1;
  end

  assign start          = (state == IDLE) & reqValid;
  assign step           = (state == ITER) & ~wZero;
  assign capture        = (state == POST);
  assign remainingSteps = cnt;
  assign rspValid       = (state == HOLD) & (rspCredits != '0);

  //////////////////////////////
  // Credits
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) rspCredits <= '0;
    else if (rspCredit && !rspValid) rspCredits <= rspCredits + 1'b1;
    else if (!rspCredit && rspValid) rspCredits <= rspCredits - 1'b1;
  end

  // Initial grant, then one credit back per result
  always_ff @(posedge clk) begin
    if (rst) begin
      initLeft  <= DIVBLEN'(REQCREDITS);
      reqCredit <= 1'b0;
    end else begin
      reqCredit <= rspValid | (initLeft != '0);
      if (!rspValid && initLeft != '0) initLeft <= initLeft - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/divPostproc.sv */
`timescale 1ns/1ps
`default_nettype none

module divPostproc (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  capture,
  input  divTypesPkg::residualT WS,
  input  divTypesPkg::residualT WC,
  input  divTypesPkg::residualT D,
  input  divTypesPkg::quotT     U,
  input  divTypesPkg::quotT     UM,
  input  logic                  wZero,
  input  divTypesPkg::shiftT    remainingSteps,  // Digits skipped by early exit
  input  divTypesPkg::shiftT    intNormShift,
  input  logic                  bZero,
  input  logic                  aLtB,
  input  logic                  aSign,
  input  logic                  negQuot,
  input  logic                  reqRem,
  input  divTypesPkg::xlenT     aOrig,
  output divTypesPkg::xlenT     rspData,
  output logic                  rspExact
);

  import divCfgPkg::*;
  import divTypesPkg::*;

  logic                   remOp;       // Remainder requested
  residualT               sum;
  logic                   negW;
  quotT                   preQ;
  residualT               unsignedQuot;
  residualT               remD;        // Corrected remainder, still scaled
  residualT               normRem;
  residualT               normQuot;
  logic signed [RESW-1:0] preResult;
  logic signed [RESW-1:0] shifted;
  shiftT                  shiftAmt;
  xlenT                   intResult;
  logic                   exactNext;

  always_ff @(posedge clk) begin
    if (rst) remOp <= 1'b0;
    else if (start) remOp <= reqRem;
  end

  //////////////////////////////
  // Residual correction
  //////////////////////////////

  assign sum  = WS + WC;
  assign negW = sum[RESW-1];
  assign preQ = negW ? UM : U;  // Negative residual means one too many
  assign remD = negW ? sum + D : sum;

  // Skipped digits are zeros below the partial quotient
  assign unsignedQuot = {{(RESW-DIVb-1){1'b0}}, preQ} << remainingSteps;

  // Sign fix, remainder follows the dividend
  assign normRem  = aSign ? -remD : remD;
  assign normQuot = negQuot ? -unsignedQuot : unsignedQuot;

  assign preResult = remOp ? normRem : normQuot;
  assign shiftAmt  = remOp ? intNormShift : '0;  // Quotient already integer
  assign shifted   = preResult >>> shiftAmt;      // Low bits are zero, shift is exact

  // Special cases finish without the recurrence
  always_comb begin
    if (bZero) begin
      if (remOp) intResult = aOrig;
      else intResult = '1;
    end else if (aLtB) begin
      if (remOp) intResult = aOrig;
      else intResult = '0;
    end else begin
      intResult = shifted[XLEN-1:0];
    end
  end

  // Exact when the true remainder is zero
  assign exactNext = (bZero | aLtB) ? (aOrig == '0) : (wZero | (remD == '0));

  always_ff @(posedge clk) begin
    if (capture) rspData <= intResult;
  end

  always_ff @(posedge clk) begin
    if (rst) rspExact <= 1'b0;
    else if (capture) rspExact <= exactNext;
  end

endmodule

`default_nettype wire

/* verilog/divEarlyTerm.sv */
`timescale 1ns/1ps
`default_nettype none

module divEarlyTerm (
  input  divTypesPkg::residualT WS,
  input  divTypesPkg::residualT WC,
  output logic                  wZero  // WS + WC == 0
);

  import divCfgPkg::*;
  import divTypesPkg::*;

  residualT prop;      // Per-bit propagate
  residualT carryIn;   // Carries a zero sum would need

  // A zero sum needs a carry into every bit with propagate set,
  // and then every set bit of either operand carries out
  assign prop    = WS ^ WC;
  assign carryIn = {(WS[RESW-2:0] | WC[RESW-2:0]), 1'b0};

  // No long carry chain in the compare
  assign wZero = (prop == carryIn);

endmodule

`default_nettype wire

/* verilog/divIter.sv */
`timescale 1ns/1ps
`default_nettype none

module divIter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  step,   // Retire one quotient digit
  input  divTypesPkg::residualT aNorm,
  input  divTypesPkg::residualT dNorm,
  output divTypesPkg::residualT WS,
  output divTypesPkg::residualT WC,
  output divTypesPkg::residualT D,
  output divTypesPkg::quotT     U,
  output divTypesPkg::quotT     UM
);

  import divCfgPkg::*;
  import divTypesPkg::*;

  logic       load;      // Preprocessed operands valid this cycle
  residualT   wsShift;
  residualT   wcShift;
  residualT   dTerm;     // -q*D in two's complement pieces
  residualT   carry;
  residualT   wsNext;
  residualT   wcNext;
  logic [3:0] est;       // Truncated estimate of 2w
  logic       qPos;
  logic       qNeg;
  quotT       uNext;
  quotT       umNext;

  // Preproc settles one cycle after start
  always_ff @(posedge clk) begin
    if (rst) load <= 1'b0;
    else load <= start;
  end

  //////////////////////////////
  // Digit selection
  //////////////////////////////

  assign wsShift = WS << LOGR;
  assign wcShift = WC << LOGR;
  assign est     = wsShift[RESW-1 -: 4] + wcShift[RESW-1 -: 4];
  assign qPos    = ~est[3];                     // Estimate >= 0
  assign qNeg    = est[3] & (est != 4'b1111);   // Estimate <= -2

  always_comb begin
    if (qPos) dTerm = ~D;       // Carry-in completes the subtract
    else if (qNeg) dTerm = D;
    else dTerm = '0;
  end

  // 3:2 compression of 2WS + 2WC - qD
  assign carry  = (wsShift & wcShift) | (wsShift & dTerm) | (wcShift & dTerm);
  assign wsNext = wsShift ^ wcShift ^ dTerm;
  assign wcNext = {carry[RESW-2:0], qPos};

  //////////////////////////////
  // On-the-fly conversion
  //////////////////////////////

  always_comb begin
    if (qPos) begin
      uNext  = {U[DIVb-1:0], 1'b1};
      umNext = {U[DIVb-1:0], 1'b0};
    end else if (qNeg) begin
      uNext  = {UM[DIVb-1:0], 1'b1};
      umNext = {UM[DIVb-1:0], 1'b0};
    end else begin
      uNext  = {U[DIVb-1:0], 1'b0};
      umNext = {UM[DIVb-1:0], 1'b1};  // UM tracks U - 1
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      WS <= aNorm;
      WC <= '0;
      D  <= dNorm;
      U  <= '0;
      UM <= '1;  // Minus one
    end else if (step) begin
      WS <= wsNext;
      WC <= wcNext;
      U  <= uNext;
      UM <= umNext;
    end
  end

endmodule

`default_nettype wire

/* verilog/divPreproc.sv */
`timescale 1ns/1ps
`default_nettype none

module divPreproc (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,         // Request accepted
  input  divTypesPkg::xlenT     reqA,
  input  divTypesPkg::xlenT     reqB,
  input  logic                  reqSigned,
  output divTypesPkg::residualT aNorm,         // Initial residual x/2
  output divTypesPkg::residualT dNorm,         // Divisor in [1,2)
  output divTypesPkg::shiftT    iterCount,     // Quotient bits to produce
  output divTypesPkg::shiftT    intNormShift,  // Remainder back to integer
  output logic                  bZero,
  output logic                  aLtB,
  output logic                  aSign,
  output logic                  bSign,
  output logic                  negQuot,
  output divTypesPkg::xlenT     aOrig
);

  import divCfgPkg::*;
  import divTypesPkg::*;

  xlenT  aReg;
  xlenT  bReg;
  logic  signedReg;
  xlenT  posA;
  xlenT  posB;
  xlenT  aLeft;
  xlenT  bLeft;
  shiftT ell;  // Leading zeros of |A|
  shiftT mE;   // Leading zeros of |B|

  // Leading zero count, XLEN for a zero word
  function automatic shiftT countLz(input xlenT v);
    shiftT n;
    n = shiftT'(XLEN);
    for (int i = 0; i < XLEN; i++) begin
      if (v[i]) n = shiftT'(XLEN - 1 - i);  // Highest set bit wins
    end
    return n;
  endfunction

  // Operands held for the whole operation
  always_ff @(posedge clk) begin
    if (start) begin
      aReg <= reqA;
      bReg <= reqB;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) signedReg <= 1'b0;
    else if (start) signedReg <= reqSigned;
  end

  assign aSign   = signedReg & aReg[XLEN-1];
  assign bSign   = signedReg & bReg[XLEN-1];
  assign negQuot = aSign ^ bSign;
  assign posA    = aSign ? -aReg : aReg;  // Most negative value stays 2^31 unsigned
  assign posB    = bSign ? -bReg : bReg;

  assign ell   = countLz(posA);
  assign mE    = countLz(posB);
  assign aLeft = posA << ell;
  assign bLeft = posB << mE;

  // Dividend lands at x/2 so that |w0| <= d
  assign aNorm = {{(RESW-XLEN){1'b0}}, aLeft};
  assign dNorm = {{(RESW-XLEN-1){1'b0}}, bLeft, 1'b0};

  assign bZero        = (bReg == '0);
  assign aLtB         = (ell > mE);        // A has more leading zeros
  assign iterCount    = mE - ell + 1'b1;   // Only meaningful when !aLtB
  assign intNormShift = mE + 1'b1;
  assign aOrig        = aReg;

endmodule

`default_nettype wire

/* verilog/divTypesPkg.sv */
`default_nettype none

package divTypesPkg;

  // Operand and result word
  typedef logic [divCfgPkg::XLEN-1:0] xlenT;

  // Carry-save residual halves and divisor, Q4.DIVb
  typedef logic [divCfgPkg::RESW-1:0] residualT;

  // Integer quotient and quotient minus one
  typedef logic [divCfgPkg::DIVb:0] quotT;

  // Shift amounts and step counts
  typedef logic [divCfgPkg::DIVBLEN-1:0] shiftT;

  //////////////////////////////
  // Sequencer states
  //////////////////////////////

  typedef enum logic [2:0] {
    IDLE,  // Waiting for a request
    PRE,   // Operands registered
    ITER,  // One digit per cycle
    POST,  // Result captured
    HOLD   // Result waits for a credit
  } divStateT;

endpackage

`default_nettype wire

/* verilog/divCfgPkg.sv */
`default_nettype none

package divCfgPkg;

  //////////////////////////////
  // Datapath sizes
  //////////////////////////////

  localparam int unsigned XLEN    = 32;        // Operand and result width
  localparam int unsigned DIVb    = 32;        // Quotient bits held in U
  localparam int unsigned LOGR    = 1;         // Radix 2 only
  localparam int unsigned DIVBLEN = 6;         // Counts up to XLEN
  localparam int unsigned RESW    = DIVb + 4;  // Residual is Q4.DIVb

  //////////////////////////////
  // Flow control
  //////////////////////////////

  // Request credits handed to the requester once reset is released
  localparam int unsigned REQCREDITS = 1;

endpackage

`default_nettype wire
